/* rtl/dbx_joy_config.svh */
// build options for the user port joystick reader
// include from any block that needs pad sizes or step counts

`ifndef DBX_JOY_CONFIG_SVH
`define DBX_JOY_CONFIG_SVH

// pad buttons forwarded to the core, 1 to 6
`define DBX_BUTTONS 2

// width of the line step counters in both readers
`define DBX_HS_CNTW 5

// line strobes spent on one Mega Drive pad
`define DBX_MD_STEPS 8

// bits shifted out of one Neo Geo pad
`define DBX_NEO_BITS 12

`endif

/* rtl/dbx_joy_pkg.sv */
// types shared by the pad readers, the mixer and the testbench
// import wherever a pad word or a port pin group is handled

`default_nettype none

package dbx_joy_pkg;

    // one decoded pad, all active high
    typedef struct packed {
        logic       mode;
        logic       start;
        logic [5:0] buttons;    // A in bit 0
        logic [3:0] dirs;       // up in bit 0, then down, left, right
    } joy_word_t;

    // result of one reader scan
    typedef struct packed {
        logic      hooked;
        joy_word_t joy1;
        joy_word_t joy0;
    } pad_pair_t;

    // DB9 lines read with select high
    // the 6-button extra cycle reuses this as z, y, x, mode
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic b;
        logic c;
    } md_hi_t;

    // DB9 lines read with select low
    typedef struct packed {
        logic up;
        logic down;
        logic zero_l;
        logic zero_r;
        logic a;
        logic start;
    } md_lo_t;

    // same six port lines, decoded by select level
    typedef union packed {
        md_hi_t hi;
        md_lo_t lo;
    } md_bus_t;

    // control pins going back out through the port
    typedef struct packed {
        logic sel;
        logic split;
        logic jclk;
        logic loadb;
    } port_ctrl_t;

endpackage

`default_nettype wire

/* rtl/user_port_io.sv */
// user port front end shared by the DB9 and DB15 readers
// latches the pins, makes the line strobe and hands the port to one reader

`timescale 1ns/1ns
`default_nettype none

module user_port_io (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    hs,
    input  logic [7:0]              user_in,
    input  dbx_joy_pkg::port_ctrl_t md_ctrl,
    input  dbx_joy_pkg::port_ctrl_t neo_ctrl,
    input  logic                    md_sample,
    input  logic                    neo_sample,
    output logic [7:0]              user_out,
    output logic                    line_stb,
    output logic                    scan_md,
    output logic                    scan_neo,
    output dbx_joy_pkg::md_bus_t    md_din,
    output logic                    neo_din
);
    import dbx_joy_pkg::*;

    logic [7:0] latch;
    logic       hs_d;
    // one-hot owner with md in bit 0
    logic [1:0] scan;
    port_ctrl_t own;

    // ============================================================
    // input side
    // ============================================================
    always_ff @(posedge clk) begin
        latch <= user_in;
    end

    // DB9 lines in md_bus_t order
    assign md_din  = {latch[6], latch[3], latch[5], latch[7], latch[1], latch[2]};
    // DB15 serial data
    assign neo_din = latch[5];

    // one clk strobe per hs rising edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hs_d     <= 1'b0;
            line_stb <= 1'b0;
        end else begin
            hs_d     <= hs;
            line_stb <= hs & ~hs_d;
        end
    end

    // ============================================================
    // port ownership
    // ============================================================
    // swap owner once the current owner finishes its scan
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan <= 2'b01;
        end else if ((scan[0] & md_sample) | (scan[1] & neo_sample)) begin
            scan <= {scan[0], scan[1]};
        end
    end

    assign scan_md  = scan[0];
    assign scan_neo = scan[1];

    // the idle reader's pins come from the owner's constant highs
    assign own = scan[0] ? md_ctrl : neo_ctrl;

    // unused pins stay high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            user_out <= 8'hef;
        end else begin
            user_out <= {3'b111, own.split, 1'b1, own.loadb, own.jclk, own.sel};
        end
    end

    // exactly one reader on the port at any time
    a_one_owner: assert property (@(posedge clk) disable iff (rst) scan_md != scan_neo)
        else $error("both or neither reader own the user port");

endmodule

`default_nettype wire

/* rtl/md_pad_reader.sv */
// Mega Drive reader for two pads on the DB9 bus
// walks the select sequence one line at a time, spots 3 and 6 button pads

`timescale 1ns/1ns
`default_nettype none

`include "dbx_joy_config.svh"

module md_pad_reader (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    line_stb,
    input  logic                    scan,
    input  dbx_joy_pkg::md_bus_t    md_din,
    output dbx_joy_pkg::port_ctrl_t md_ctrl,
    output logic                    sample,
    output dbx_joy_pkg::pad_pair_t  pads
);
    import dbx_joy_pkg::*;

    localparam int unsigned STEPS = `DBX_MD_STEPS;
    localparam int unsigned LAST  = 2 * STEPS - 1;

    logic [`DBX_HS_CNTW-1:0] cnt;
    logic [`DBX_HS_CNTW-1:0] step;
    logic                    pad1;
    logic                    sel;
    logic                    split;
    logic                    present;
    logic                    six;
    logic                    hook0;
    joy_word_t               cur;
    joy_word_t               fin;
    joy_word_t               joy0_r;

    // second half of the count belongs to pad 1
    assign pad1 = cnt >= STEPS;
    assign step = pad1 ? cnt - `DBX_HS_CNTW'(STEPS) : cnt;

    // ============================================================
    // sequencer
    // ============================================================
    // select toggles every line, starting high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt    <= '0;
            sel    <= 1'b1;
            split  <= 1'b0;
            sample <= 1'b0;
            pads   <= '0;
        end else begin
            sample <= 1'b0;
            if (line_stb && scan) begin
                sel   <= ~step[0];
                split <= pad1;
                if (cnt == LAST) begin
                    cnt    <= '0;
                    sample <= 1'b1;
                    pads   <= '{hooked: hook0 | present, joy1: fin, joy0: joy0_r};
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // ============================================================
    // data capture
    // ============================================================
    // each step reads the lines set up by the previous select
    always_ff @(posedge clk) begin
        if (line_stb && scan) begin
            case (step)
                0: cur <= '0;
                1: begin
                    cur.dirs       <= ~{md_din.hi.right, md_din.hi.left,
                                        md_din.hi.down, md_din.hi.up};
                    cur.buttons[1] <= ~md_din.hi.b;
                    cur.buttons[2] <= ~md_din.hi.c;
                end
                2: begin
                    // both side lines pulled low only by a real pad
                    present        <= ~(md_din.lo.zero_l | md_din.lo.zero_r);
                    cur.buttons[0] <= ~md_din.lo.a;
                    cur.start      <= ~md_din.lo.start;
                end
                // third low select on a 6-button pad
                6: six <= ~(md_din.hi.up | md_din.hi.down | md_din.hi.left | md_din.hi.right);
                7: begin
                    if (!pad1) begin
                        joy0_r <= fin;
                        hook0  <= present;
                    end
                end
                default: ;
            endcase
        end
    end

    // finished word with the extra buttons of a 6-button pad
    always_comb begin
        fin = cur;
        if (six) begin
            fin.buttons[5] = ~md_din.hi.up;
            fin.buttons[4] = ~md_din.hi.down;
            fin.buttons[3] = ~md_din.hi.left;
            fin.mode       = ~md_din.hi.right;
        end
        if (!present) begin
            fin = '0;
        end
    end

    assign md_ctrl = '{sel: sel, split: split, jclk: 1'b1, loadb: 1'b1};

    a_sample_on_line: assert property (@(posedge clk) disable iff (rst)
        sample |-> $past(line_stb && scan))
        else $error("md sample outside a line step");

endmodule

`default_nettype wire

/* rtl/neo_pad_reader.sv */
// Neo Geo reader for two pads behind a DB15 serial adapter
// one load line then 25 shift lines, last bit tells if the adapter is there

`timescale 1ns/1ns
`default_nettype none

`include "dbx_joy_config.svh"

module neo_pad_reader (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    line_stb,
    input  logic                    scan,
    input  logic                    neo_din,
    output dbx_joy_pkg::port_ctrl_t neo_ctrl,
    output logic                    sample,
    output dbx_joy_pkg::pad_pair_t  pads
);
    import dbx_joy_pkg::*;

    // both pads plus the hook bit
    localparam int unsigned BITS = 2 * `DBX_NEO_BITS + 1;

    logic [`DBX_HS_CNTW-1:0] cnt;
    logic                    loadb;
    logic                    jclk;
    logic [BITS-2:0]         sr;
    logic [BITS-1:0]         sr_nx;

    // MSB first, joy0 leads the chain
    assign sr_nx = {sr, neo_din};

    // ============================================================
    // load and shift sequence
    // ============================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt    <= '0;
            loadb  <= 1'b1;
            jclk   <= 1'b0;
            sample <= 1'b0;
            pads   <= '0;
        end else begin
            // shift clock is a single clk pulse per line
            jclk   <= 1'b0;
            sample <= 1'b0;
            if (line_stb && scan) begin
                if (cnt == 0) begin
                    loadb <= 1'b0;
                    cnt   <= cnt + 1'b1;
                end else begin
                    loadb <= 1'b1;
                    jclk  <= 1'b1;
                    if (cnt == BITS) begin
                        cnt    <= '0;
                        sample <= 1'b1;
                        // chain lines are active low
                        pads   <= '{hooked: ~sr_nx[0],
                                    joy1:   joy_word_t'(~sr_nx[`DBX_NEO_BITS:1]),
                                    joy0:   joy_word_t'(~sr_nx[BITS-1 -: `DBX_NEO_BITS])};
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            end
        end
    end

    // din is taken before this line's clock edge moves the chain
    always_ff @(posedge clk) begin
        if (line_stb && scan && cnt != 0) begin
            sr <= sr_nx[BITS-2:0];
        end
    end

    assign neo_ctrl = '{sel: 1'b1, split: 1'b1, jclk: jclk, loadb: loadb};

    a_load_vs_clk: assert property (@(posedge clk) disable iff (rst) !loadb |-> !jclk)
        else $error("shift clock raised during load");

endmodule

`default_nettype wire

/* rtl/joy_mixer.sv */
// merges the reader results with the USB joystick words
// neo adapter wins over md pads, outputs are registered

`timescale 1ns/1ns
`default_nettype none

`include "dbx_joy_config.svh"

module joy_mixer (
    input  logic                   clk,
    input  logic                   rst,
    input  dbx_joy_pkg::pad_pair_t md_pads,
    input  dbx_joy_pkg::pad_pair_t neo_pads,
    input  logic [15:0]            usb_joy0,
    input  logic [15:0]            usb_joy1,
    output logic [15:0]            mix_joy0,
    output logic [15:0]            mix_joy1,
    output logic [5:0]             raw_joy,
    output logic [1:0]             start,
    output logic [1:0]             coin,
    output logic                   user_osd
);
    import dbx_joy_pkg::*;

    localparam int unsigned BTN = `DBX_BUTTONS;
    // buttons the core never sees
    localparam logic [5:0] FREE = 6'h3f << BTN;

    joy_word_t w0;
    joy_word_t w1;
    logic      use_md;

    // ============================================================
    // source select
    // ============================================================
    always_comb begin
        use_md = 1'b0;
        if (neo_pads.hooked) begin
            w0 = neo_pads.joy0;
            w1 = neo_pads.joy1;
        end else if (md_pads.hooked) begin
            w0     = md_pads.joy0;
            w1     = md_pads.joy1;
            use_md = 1'b1;
        end else begin
            w0 = '0;
            w1 = '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mix_joy0 <= '0;
            mix_joy1 <= '0;
            raw_joy  <= '0;
            start    <= '0;
            coin     <= '0;
            user_osd <= 1'b0;
        end else begin
            mix_joy0 <= {{(12 - BTN){1'b0}}, w0[BTN+3:0]} | usb_joy0;
            mix_joy1 <= {{(12 - BTN){1'b0}}, w1[BTN+3:0]} | usb_joy1;
            raw_joy  <= w0[5:0] | w1[5:0];
            start    <= {w1.start, w0.start};
            // md pads may borrow a spare button as coin
            coin[0]  <= w0.mode | (use_md & |(w0.buttons & FREE));
            coin[1]  <= w1.mode | (use_md & |(w1.buttons & FREE));
            user_osd <= w0.start & w0.buttons[2];
        end
    end

endmodule

`default_nettype wire

/* rtl/dbx_joy.sv */
// top of the user port joystick reader
// DB9 and DB15 readers share the port and feed the mixer

`timescale 1ns/1ns
`default_nettype none

module dbx_joy (
    input  logic        clk,
    input  logic        rst,
    input  logic        hs,
    input  logic [15:0] usb_joy0,
    input  logic [15:0] usb_joy1,
    input  logic [7:0]  user_in,
    output logic [7:0]  user_out,
    output logic [15:0] mix_joy0,
    output logic [15:0] mix_joy1,
    output logic [5:0]  raw_joy,
    output logic [1:0]  start,
    output logic [1:0]  coin,
    output logic        user_osd
);
    import dbx_joy_pkg::*;

    logic       line_stb;
    logic       scan_md;
    logic       scan_neo;
    logic       md_sample;
    logic       neo_sample;
    logic       neo_din;
    md_bus_t    md_din;
    port_ctrl_t md_ctrl;
    port_ctrl_t neo_ctrl;
    pad_pair_t  md_pads;
    pad_pair_t  neo_pads;

    user_port_io u_port (
        .clk, .rst, .hs, .user_in, .md_ctrl, .neo_ctrl, .md_sample, .neo_sample,
        .user_out, .line_stb, .scan_md, .scan_neo, .md_din, .neo_din
    );

    md_pad_reader u_md (
        .clk, .rst, .line_stb, .scan(scan_md), .md_din,
        .md_ctrl, .sample(md_sample), .pads(md_pads)
    );

    neo_pad_reader u_neo (
        .clk, .rst, .line_stb, .scan(scan_neo), .neo_din,
        .neo_ctrl, .sample(neo_sample), .pads(neo_pads)
    );

    joy_mixer u_mix (
        .clk, .rst, .md_pads, .neo_pads, .usb_joy0, .usb_joy1,
        .mix_joy0, .mix_joy1, .raw_joy, .start, .coin, .user_osd
    );

endmodule

`default_nettype wire

/* test/dbx_joy_tb.sv */
// directed testbench for the user port joystick reader
// models DB9 and DB15 pads on the port pins, checks the mixer outputs

`timescale 1ns/1ns
`default_nettype none

`include "dbx_joy_config.svh"

module dbx_joy_tb;
    import dbx_joy_pkg::*;

    // two full scans of both readers, plus a few lines of slack
    localparam int LINE_LIMIT = 2 * (2 * `DBX_MD_STEPS + 2 * `DBX_NEO_BITS + 2) + 4;

    logic        clk;
    logic        rst;
    logic        hs = 1'b0;
    logic [15:0] usb_joy0;
    logic [15:0] usb_joy1;
    logic [7:0]  user_in = 8'hff;
    logic [7:0]  user_out;
    logic [15:0] mix_joy0;
    logic [15:0] mix_joy1;
    logic [5:0]  raw_joy;
    logic [1:0]  start;
    logic [1:0]  coin;
    logic        user_osd;

    integer      seed;
    logic        hs_run = 1'b0;
    logic [3:0]  hs_phase = '0;

    // pad state seen by the models
    joy_word_t   md_joy [2];
    logic [1:0]  md_present;
    logic [1:0]  md_six;
    joy_word_t   neo_joy [2];
    logic        neo_present;

    // model internals
    int          sel_falls [2];
    logic        prev_sel = 1'b1;
    logic        prev_jclk = 1'b0;
    logic [24:0] chain = '1;
    logic        pin_sel;
    logic        pin_jclk;
    logic        pin_loadb;
    logic        pin_split;

    // expected outputs
    logic [15:0] exp_mix0;
    logic [15:0] exp_mix1;
    logic [5:0]  exp_raw;
    logic [1:0]  exp_start;
    logic [1:0]  exp_coin;
    logic        exp_osd;

    dbx_joy u_dbx_joy (
        .clk, .rst, .hs, .usb_joy0, .usb_joy1, .user_in, .user_out,
        .mix_joy0, .mix_joy1, .raw_joy, .start, .coin, .user_osd
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // hsync high 4 clk out of every 16 once started
    always @(posedge clk) begin
        #1;
        hs_phase <= hs_run ? hs_phase + 4'd1 : 4'd0;
        hs       <= hs_run && (hs_phase < 4'd4);
    end

    // ============================================================
    // pad models
    // ============================================================
    // DB9 lines of the pad picked by split, active low, user_in bit order
    function automatic logic [7:0] md_lines(input logic split, input logic sel);
        joy_word_t j;
        j = md_joy[split];
        if (!md_present[split]) begin
            return 8'hff;
        end
        // third select cycle of a 6-button pad
        if (md_six[split] && sel_falls[split] == 3) begin
            if (sel) begin
                return {~j.mode, ~j.buttons[5], ~j.buttons[3], 1'b1,
                        ~j.buttons[4], ~j.buttons[2], ~j.buttons[1], 1'b1};
            end
            return {4'b0001, 1'b0, ~j.start, ~j.buttons[0], 1'b1};
        end
        if (sel) begin
            return {~j.dirs[3], ~j.dirs[0], ~j.dirs[2], 1'b1,
                    ~j.dirs[1], ~j.buttons[2], ~j.buttons[1], 1'b1};
        end
        return {1'b0, ~j.dirs[0], 1'b0, 1'b1, ~j.dirs[1], ~j.start, ~j.buttons[0], 1'b1};
    endfunction

    // parallel load of the DB15 chain, hook bit last and low when present
    function automatic logic [24:0] load_chain();
        if (!neo_present) begin
            return '1;
        end
        return {~neo_joy[0], ~neo_joy[1], 1'b0};
    endfunction

    always @(posedge clk) begin
        #1;
        pin_sel   = user_out[0];
        pin_jclk  = user_out[1];
        pin_loadb = user_out[2];
        pin_split = user_out[4];
        // a pad counts select falls only while split points at it
        for (int p = 0; p < 2; p++) begin
            if (pin_split != 1'(p)) begin
                sel_falls[p] = 0;
            end else if (prev_sel && !pin_sel) begin
                sel_falls[p] = sel_falls[p] + 1;
            end
        end
        prev_sel = pin_sel;
        if (!pin_loadb) begin
            chain = load_chain();
        end else if (pin_jclk && !prev_jclk) begin
            chain = {chain[23:0], 1'b1};
        end
        prev_jclk = pin_jclk;
        // open drain port, pin 5 shared by DB9 left and DB15 data
        user_in <= md_lines(pin_split, pin_sel) & {2'b11, chain[24], 5'b11111};
    end

    // ============================================================
    // expected values and compare tasks
    // ============================================================
    task automatic compute_expected();
        joy_word_t   w [2];
        logic        md_src;
        logic [5:0]  spare;
        logic [11:0] keep;
        md_src = 1'b0;
        spare  = '0;
        keep   = '0;
        for (int p = 0; p < 2; p++) begin
            w[p] = '0;
            if (neo_present) begin
                w[p] = neo_joy[p];
            end else if (md_present != 2'b00) begin
                md_src = 1'b1;
                if (md_present[p]) begin
                    w[p] = md_joy[p];
                    // a 3-button pad never reports extras
                    if (!md_six[p]) begin
                        w[p].mode         = 1'b0;
                        w[p].buttons[5:3] = '0;
                    end
                end
            end
        end
        for (int b = 0; b < `DBX_BUTTONS + 4; b++) begin
            keep[b] = 1'b1;
        end
        // buttons the core never sees
        for (int b = `DBX_BUTTONS; b < 6; b++) begin
            spare[b] = 1'b1;
        end
        exp_mix0  = usb_joy0 | {4'h0, w[0] & keep};
        exp_mix1  = usb_joy1 | {4'h0, w[1] & keep};
        exp_raw   = {w[0].buttons[1:0], w[0].dirs} | {w[1].buttons[1:0], w[1].dirs};
        exp_start = {w[1].start, w[0].start};
        exp_coin  = {w[1].mode | (md_src & |(w[1].buttons & spare)),
                     w[0].mode | (md_src & |(w[0].buttons & spare))};
        exp_osd   = w[0].start & w[0].buttons[2];
    endtask

    task automatic stop_on_error();
        $display("test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string what, input logic [15:0] got, input logic [15:0] want);
        if (got !== want) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_pair(input string what, input logic [1:0] got, input logic [1:0] want);
        if (got !== want) begin
            $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic want);
        if (got !== want) begin
            $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, want);
            stop_on_error();
        end
    endtask

    function automatic logic outputs_match();
        return mix_joy0 === exp_mix0 && mix_joy1 === exp_mix1 && raw_joy === exp_raw
            && start === exp_start && coin === exp_coin && user_osd === exp_osd;
    endfunction

    task automatic compare_all();
        check_word("mix_joy0", mix_joy0, exp_mix0);
        check_word("mix_joy1", mix_joy1, exp_mix1);
        check_word("raw_joy", {10'd0, raw_joy}, {10'd0, exp_raw});
        check_pair("start", start, exp_start);
        check_pair("coin", coin, exp_coin);
        check_bit("user_osd", user_osd, exp_osd);
    endtask

    // ============================================================
    // waiting
    // ============================================================
    // next hs rising edge, bounded in clocks
    task automatic wait_line();
        logic last;
        logic seen;
        last = hs;
        seen = 1'b0;
        for (int n = 0; n < 40 && !seen; n++) begin
            @(posedge clk);
            seen = hs && !last;
            last = hs;
        end
        if (!seen) begin
            $display("hsync stopped toggling, no new line within 40 clocks");
            stop_on_error();
        end
    endtask

    // follow within two full scans, then stay put for as long again
    task automatic settle_and_check();
        compute_expected();
        for (int n = 0; n < LINE_LIMIT && !outputs_match(); n++) begin
            wait_line();
            @(negedge clk);
        end
        compare_all();
        for (int n = 0; n < LINE_LIMIT; n++) begin
            wait_line();
            @(negedge clk);
            compare_all();
        end
    endtask

    task automatic drive_usb(input logic [15:0] j0, input logic [15:0] j1);
        @(posedge clk);
        #1;
        usb_joy0 = j0;
        usb_joy1 = j1;
    endtask

    // random pad word the port can carry unambiguously
    function automatic joy_word_t random_pad(input logic [31:0] r, input logic six,
                                             input logic pad1);
        joy_word_t j;
        j = joy_word_t'(r[11:0]);
        if (!six) begin
            j.mode         = 1'b0;
            j.buttons[5:3] = '0;
        end
        // up with down would read as a 6-button cycle
        if (j.dirs[0] && j.dirs[1]) begin
            j.dirs[1] = 1'b0;
        end
        // pad 1 left sits on the DB15 data pin while the neo reader scans
        if (pad1) begin
            j.dirs[2] = 1'b0;
        end
        return j;
    endfunction

    // ============================================================
    // directed tests
    // ============================================================
    task automatic reset_state_test();
        @(negedge clk);
        compute_expected();
        compare_all();
        // shift clock bit idles per owner
        check_word("user_out idle pins", {8'h00, user_out & 8'hfd}, 16'h00ed);
    endtask

    task automatic no_pad_test();
        for (int i = 0; i < 3; i++) begin
            drive_usb(16'($random(seed)), 16'($random(seed)));
            settle_and_check();
        end
    endtask

    task automatic three_button_test();
        for (int i = 0; i < 4; i++) begin
            drive_usb(16'($random(seed)), 16'($random(seed)));
            @(negedge clk);
            md_present = 2'b11;
            md_six     = 2'b00;
            md_joy[0]  = random_pad($random(seed), 1'b0, 1'b0);
            md_joy[1]  = random_pad($random(seed), 1'b0, 1'b1);
            settle_and_check();
        end
    endtask

    task automatic six_button_test();
        drive_usb(16'h0000, 16'h0000);
        @(negedge clk);
        md_six                 = 2'b11;
        // pad 0 coin comes from mode alone
        md_joy[0]              = random_pad($random(seed), 1'b1, 1'b0);
        md_joy[0].mode         = 1'b1;
        md_joy[0].start        = 1'b0;
        md_joy[0].buttons[5:2] = '0;
        // pad 1 coin comes from the z and x extras alone
        md_joy[1]              = random_pad($random(seed), 1'b1, 1'b1);
        md_joy[1].mode         = 1'b0;
        md_joy[1].buttons[5:2] = 4'b1010;
        settle_and_check();
        check_pair("coin from pad 0 mode and pad 1 extras", coin, 2'b11);
        // start plus button 2 opens the menu
        @(negedge clk);
        md_joy[0].start      = 1'b1;
        md_joy[0].buttons[2] = 1'b1;
        settle_and_check();
        check_bit("user_osd on start and button 2", user_osd, 1'b1);
    endtask

    task automatic neo_wins_test();
        for (int i = 0; i < 2; i++) begin
            drive_usb(16'($random(seed)), 16'($random(seed)));
            @(negedge clk);
            md_present  = 2'b11;
            md_six      = 2'b00;
            md_joy[0]   = random_pad($random(seed), 1'b0, 1'b0);
            md_joy[1]   = random_pad($random(seed), 1'b0, 1'b1);
            neo_present = 1'b1;
            neo_joy[0]  = joy_word_t'(12'($random(seed)));
            neo_joy[1]  = joy_word_t'(12'($random(seed)));
            settle_and_check();
        end
    endtask

    task automatic unplug_test();
        drive_usb(16'($random(seed)), 16'($random(seed)));
        @(negedge clk);
        md_present  = 2'b00;
        neo_present = 1'b0;
        settle_and_check();
    endtask

    initial begin
        seed        = 32'h5ccc11a3;
        rst         = 1'b1;
        usb_joy0    = '0;
        usb_joy1    = '0;
        md_present  = 2'b00;
        md_six      = 2'b00;
        neo_present = 1'b0;
        md_joy[0]   = '0;
        md_joy[1]   = '0;
        neo_joy[0]  = '0;
        neo_joy[1]  = '0;
        sel_falls[0] = 0;
        sel_falls[1] = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_state_test();
        @(negedge clk);
        hs_run = 1'b1;
        no_pad_test();
        three_button_test();
        six_button_test();
        neo_wins_test();
        unplug_test();
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* dbx_joy.f */
+incdir+rtl
rtl/dbx_joy_pkg.sv
rtl/user_port_io.sv
rtl/md_pad_reader.sv
rtl/neo_pad_reader.sv
rtl/joy_mixer.sv
rtl/dbx_joy.sv
test/dbx_joy_tb.sv

/* Makefile */
# Verilator build and run of the user port joystick testbench
# override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= dbx_joy_tb
FILELIST  ?= dbx_joy.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard rtl/*.sv rtl/*.svh test/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
